/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [29:0] wordAddrT;
    typedef logic [4:0]  regAddrT;
    typedef logic [3:0]  aluOpT;
    typedef logic [1:0]  fwdSelT;

    // Primary opcodes
    localparam logic [5:0] opR     = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opSltiu = 6'h0b;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opXori  = 6'h0e;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // R-type function field
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    localparam aluOpT aluAdd  = 4'd0;
    localparam aluOpT aluSub  = 4'd1;
    localparam aluOpT aluAnd  = 4'd2;
    localparam aluOpT aluOr   = 4'd3;
    localparam aluOpT aluXor  = 4'd4;
    localparam aluOpT aluNor  = 4'd5;
    localparam aluOpT aluSlt  = 4'd6;
    localparam aluOpT aluSltu = 4'd7;
    localparam aluOpT aluSll  = 4'd8;
    localparam aluOpT aluSrl  = 4'd9;
    localparam aluOpT aluSra  = 4'd10;
    localparam aluOpT aluLui  = 4'd11;

    // Operand source for decode and execute
    localparam fwdSelT fwdReg = 2'd0;
    localparam fwdSelT fwdMem = 2'd1;
    localparam fwdSelT fwdWb  = 2'd2;

    localparam wordT resetPc = 32'h0000_0000;

endpackage

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     stall,
    input  logic     pcSel,
    input  wordT     target,
    input  wordT     instIn,
    output wordAddrT instAddr,
    output wordT     decInstr,
    output wordT     decPcPlus4
);

    wordT pc;
    wordT pcPlus4;

    assign pcPlus4  = pc + 32'd4;
    assign instAddr = pc[31:2];

    // Target comes from decode while the delay slot is being fetched
    always_ff @(posedge clk)
    begin
        if (!rstN)
            pc <= resetPc;
        else if (!stall)
            pc <= pcSel ? target : pcPlus4;
    end

    // All-zero word is sll r0,r0,0 so decode starts on a nop
    always_ff @(posedge clk)
    begin
        if (!rstN)
            decInstr <= '0;
        else if (!stall)
            decInstr <= instIn;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
            decPcPlus4 <= pcPlus4;
    end

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import mipsPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  wordT    decInstr,
    input  wordT    decPcPlus4,
    input  fwdSelT  rsFwdDec,
    input  fwdSelT  rtFwdDec,
    input  wordT    memResult,
    input  wordT    wbData,
    input  regAddrT wbDest,
    input  logic    wbWrite,
    output logic    pcSel,
    output wordT    target,
    output regAddrT decRs,
    output regAddrT decRt,
    output logic    decIsBranch,
    output wordT    exA,
    output wordT    exB,
    output wordT    exImm,
    output regAddrT exRs,
    output regAddrT exRt,
    output regAddrT exDest,
    output regAddrT exShamt,
    output aluOpT   exAluOp,
    output logic    exAluSrcImm,
    output logic    exMemRead,
    output logic    exMemWrite,
    output logic    exRegWrite
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    regAddrT     rd;
    regAddrT     dest;
    wordT        rsVal;
    wordT        rtVal;
    wordT        immExt;
    aluOpT       aluOp;
    logic        isRType, isJump, isBeq, isBne;
    logic        zeroExt, regWrite, operandsEq;
    wordT        regFile [0:31];

    assign opcode = decInstr[31:26];
    assign decRs  = decInstr[25:21];
    assign decRt  = decInstr[20:16];
    assign rd     = decInstr[15:11];
    assign funct  = decInstr[5:0];
    assign imm16  = decInstr[15:0];

    always_ff @(posedge clk)
    begin
        if (wbWrite)
            regFile[wbDest] <= wbData;
    end

    // Register read, then forwarding from memory or writeback
    function automatic wordT operand(input regAddrT addr, input fwdSelT sel);
        if (sel == fwdMem)
            return memResult;
        if (sel == fwdWb)
            return wbData;
        return (addr == '0) ? '0 : regFile[addr];
    endfunction

    always_comb
    begin
        rsVal = operand(decRs, rsFwdDec);
        rtVal = operand(decRt, rtFwdDec);
    end

    always_comb
    begin
        case (opcode)
            opR:
                case (funct)
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnSra:   aluOp = aluSra;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnNor:   aluOp = aluNor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    default: aluOp = aluAdd;
                endcase
            opSlti:  aluOp = aluSlt;
            opSltiu: aluOp = aluSltu;
            opAndi:  aluOp = aluAnd;
            opOri:   aluOp = aluOr;
            opXori:  aluOp = aluXor;
            opLui:   aluOp = aluLui;
            default: aluOp = aluAdd;
        endcase
    end

    assign isRType  = opcode == opR;
    assign zeroExt  = opcode inside {opAndi, opOri, opXori};
    assign immExt   = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
    assign dest     = isRType ? rd : decRt;
    // Unknown function codes write nothing
    assign regWrite = (isRType && funct inside {fnSll, fnSrl, fnSra, fnAddu, fnSubu, fnAnd,
                                                fnOr, fnXor, fnNor, fnSlt, fnSltu})
                      || opcode inside {opAddiu, opSlti, opSltiu, opAndi, opOri, opXori,
                                        opLui, opLw};

    // Branch resolution
    assign isJump      = opcode == opJ;
    assign isBeq       = opcode == opBeq;
    assign isBne       = opcode == opBne;
    assign decIsBranch = isBeq || isBne;
    assign operandsEq  = rsVal == rtVal;
    assign pcSel       = isJump || (isBeq && operandsEq) || (isBne && !operandsEq);
    assign target      = isJump ? {decPcPlus4[31:28], decInstr[25:0], 2'b00}
                                : decPcPlus4 + {immExt[29:0], 2'b00};

    // Stall sends a bubble into execute
    always_ff @(posedge clk)
    begin
        if (!rstN || stall)
        begin
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exRegWrite <= 1'b0;
        end
        else
        begin
            exMemRead  <= opcode == opLw;
            exMemWrite <= opcode == opSw;
            exRegWrite <= regWrite && dest != '0;
        end
    end

    always_ff @(posedge clk)
    begin
        exA         <= rsVal;
        exB         <= rtVal;
        exImm       <= immExt;
        exRs        <= decRs;
        exRt        <= decRt;
        exDest      <= dest;
        exShamt     <= decInstr[10:6];
        exAluOp     <= aluOp;
        exAluSrcImm <= !isRType;
    end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
    import mipsPkg::*;
(
    input  regAddrT decRs,
    input  regAddrT decRt,
    input  regAddrT exRs,
    input  regAddrT exRt,
    input  regAddrT exDest,
    input  regAddrT memDest,
    input  regAddrT wbDest,
    input  logic    decIsBranch,
    input  logic    exRegWrite,
    input  logic    exMemRead,
    input  logic    memRegWrite,
    input  logic    memMemRead,
    input  logic    wbWrite,
    output logic    stall,
    output fwdSelT  rsFwdDec,
    output fwdSelT  rtFwdDec,
    output fwdSelT  rsFwdEx,
    output fwdSelT  rtFwdEx
);

    logic exMatch;
    logic memLoadMatch;

    // Memory stage only holds an address for a load, so its data comes from writeback
    function automatic fwdSelT pickFwd(input regAddrT src);
        if (src == '0)
            return fwdReg;
        if (memRegWrite && !memMemRead && memDest == src)
            return fwdMem;
        if (wbWrite && wbDest == src)
            return fwdWb;
        return fwdReg;
    endfunction

    always_comb
    begin
        rsFwdDec = pickFwd(decRs);
        rtFwdDec = pickFwd(decRt);
        rsFwdEx  = pickFwd(exRs);
        rtFwdEx  = pickFwd(exRt);
    end

    assign exMatch      = exRegWrite && (exDest == decRs || exDest == decRt);
    assign memLoadMatch = memRegWrite && memMemRead && (memDest == decRs || memDest == decRt);

    // Load-use waits one cycle, a branch waits until its operand can be forwarded
    assign stall = (exMemRead && exMatch)
                   || (decIsBranch && exMatch)
                   || (decIsBranch && memLoadMatch);

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import mipsPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  wordT    exA,
    input  wordT    exB,
    input  wordT    exImm,
    input  regAddrT exShamt,
    input  regAddrT exDest,
    input  aluOpT   exAluOp,
    input  logic    exAluSrcImm,
    input  logic    exMemRead,
    input  logic    exMemWrite,
    input  logic    exRegWrite,
    input  fwdSelT  rsFwdEx,
    input  fwdSelT  rtFwdEx,
    input  wordT    memResult,
    input  wordT    wbData,
    output wordT    memResultOut,
    output wordT    memStoreData,
    output regAddrT memDest,
    output logic    memRead,
    output logic    memWrite,
    output logic    memRegWrite
);

    wordT a;
    wordT rtVal;
    wordT b;
    wordT result;

    always_comb
    begin
        case (rsFwdEx)
            fwdMem:  a = memResult;
            fwdWb:   a = wbData;
            default: a = exA;
        endcase
        case (rtFwdEx)
            fwdMem:  rtVal = memResult;
            fwdWb:   rtVal = wbData;
            default: rtVal = exB;
        endcase
    end

    assign b = exAluSrcImm ? exImm : rtVal;

    // Shifts act on rt, lui on the low immediate half
    always_comb
    begin
        case (exAluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluNor:  result = ~(a | b);
            aluSlt:  result = {31'd0, $signed(a) < $signed(b)};
            aluSltu: result = {31'd0, a < b};
            aluSll:  result = b << exShamt;
            aluSrl:  result = b >> exShamt;
            aluSra:  result = $signed(b) >>> exShamt;
            aluLui:  result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            memRegWrite <= 1'b0;
        end
        else
        begin
            memRead     <= exMemRead;
            memWrite    <= exMemWrite;
            memRegWrite <= exRegWrite;
        end
    end

    always_ff @(posedge clk)
    begin
        memResultOut <= result;
        memStoreData <= rtVal;
        memDest      <= exDest;
    end

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  wordT     memResult,
    input  wordT     memStoreData,
    input  wordT     dataIn,
    input  regAddrT  memDest,
    input  logic     memRead,
    input  logic     memWrite,
    input  logic     memRegWrite,
    output wordAddrT dataAddr,
    output wordT     dataOut,
    output logic     dataRead,
    output logic     dataWrite,
    output wordT     wbData,
    output regAddrT  wbDest,
    output logic     wbWrite
);

    // Word accesses only, the low address bits are dropped
    assign dataAddr  = memResult[31:2];
    assign dataOut   = memStoreData;
    assign dataRead  = memRead;
    assign dataWrite = memWrite;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            wbWrite <= 1'b0;
        else
            wbWrite <= memRegWrite;
    end

    // Memory answers in the same cycle
    always_ff @(posedge clk)
    begin
        wbData <= memRead ? dataIn : memResult;
        wbDest <= memDest;
    end

endmodule

`default_nettype wire

/* design/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  wordT     instIn,
    input  wordT     dataIn,
    output wordAddrT instAddr,
    output wordAddrT dataAddr,
    output wordT     dataOut,
    output logic     dataRead,
    output logic     dataWrite
);

    // Fetch and decode
    logic    stall;
    logic    pcSel;
    wordT    target;
    wordT    decInstr;
    wordT    decPcPlus4;
    regAddrT decRs, decRt;
    logic    decIsBranch;

    // Decode to execute register
    wordT    exA, exB, exImm;
    regAddrT exRs, exRt, exDest, exShamt;
    aluOpT   exAluOp;
    logic    exAluSrcImm, exMemRead, exMemWrite, exRegWrite;

    // Forwarding selects
    fwdSelT  rsFwdDec, rtFwdDec, rsFwdEx, rtFwdEx;

    // Execute to memory register
    wordT    memResult, memStoreData;
    regAddrT memDest;
    logic    memRead, memWrite, memRegWrite;

    // Writeback
    wordT    wbData;
    regAddrT wbDest;
    logic    wbWrite;

    fetchStage u_fetch (.*);

    decodeStage u_decode (.*);

    hazardUnit u_hazard (
        .memMemRead (memRead),
        .*
    );

    executeStage u_execute (
        .memResultOut (memResult),
        .*
    );

    memoryStage u_memory (.*);

endmodule

`default_nettype wire

/* verification/tbMips.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMips
    import mipsPkg::*;
();

    logic     clk;
    logic     rstN;
    wordT     instIn;
    wordT     dataIn;
    wordAddrT instAddr;
    wordAddrT dataAddr;
    wordT     dataOut;
    logic     dataRead;
    logic     dataWrite;

    wordT        instMem [0:255];
    wordT        dataMem [0:255];
    logic [15:0] lfsr;
    int          progLen;
    int          storeSlot;
    int          seen;
    int          expCount;
    int          loadsSeen;
    int          loadCount;
    int          valueErrors;
    int          otherErrors;
    wordAddrT    expAddr [$];
    wordT        expData [$];
    wordAddrT    loadAddr [$];

    logic [5:0] rFuncs [0:10] = '{fnSll, fnSrl, fnSra, fnAddu, fnSubu, fnAnd,
                                  fnOr, fnXor, fnNor, fnSlt, fnSltu};
    logic [5:0] iOps [0:6] = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};

    mipsCore u_dut (.*);

    always #20 clk = ~clk;

    // Memories answer 1 ns after the edge and stores land on the edge
    always @(posedge clk)
    begin
        if (rstN && dataWrite)
            dataMem[dataAddr[7:0]] = dataOut;
        #1;
        instIn = instMem[instAddr[7:0]];
        dataIn = dataMem[dataAddr[7:0]];
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        logic        outBit;
        int          i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            outBit = lfsr[0];
            lfsr = lfsr >> 1;
            if (outBit)
                lfsr = lfsr ^ 16'hb400;
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    function automatic regAddrT randReg();
        return regAddrT'(randBits(5));
    endfunction

    function automatic wordT rType(input logic [5:0] fn, input regAddrT rd, input regAddrT rs,
                                   input regAddrT rt, input logic [4:0] sh);
        return {opR, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT iType(input logic [5:0] op, input regAddrT rt, input regAddrT rs,
                                   input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jump(input int index);
        return {opJ, 18'd0, index[7:0]};
    endfunction

    task automatic emit(input wordT ins);
        instMem[progLen[7:0]] = ins;
        progLen++;
    endtask

    // Each call stores to the next data word
    task automatic storeReg(input regAddrT rt);
        emit(iType(opSw, rt, 5'd0, {6'd0, storeSlot[7:0], 2'b00}));
        storeSlot++;
    endtask

    task automatic fillMemories();
        int i;
        for (i = 0; i < 256; i++)
        begin
            // Stray fetches trap on a jump to themselves
            instMem[i] = jump(i);
            dataMem[i] = randBits(32);
        end
    endtask

    task automatic buildDirected();
        int i;
        for (i = 1; i < 32; i++)
        begin
            emit(iType(opLui, 5'(i), 5'd0, 16'(randBits(16))));
            emit(iType(opOri, 5'(i), 5'(i), 16'(randBits(16))));
        end
        // Every ALU operation on random operands
        for (i = 0; i < 11; i++)
        begin
            emit(rType(rFuncs[i], 5'd1, randReg(), randReg(), randReg()));
            storeReg(5'd1);
        end
        for (i = 0; i < 7; i++)
        begin
            emit(iType(iOps[i], 5'd1, randReg(), 16'(randBits(16))));
            storeReg(5'd1);
        end
        // Dependent chain at distances 1, 2 and 3
        emit(rType(fnAddu, 5'd10, 5'd2, 5'd3, 5'd0));
        emit(rType(fnSubu, 5'd11, 5'd10, 5'd2, 5'd0));
        emit(rType(fnXor, 5'd12, 5'd10, 5'd11, 5'd0));
        emit(rType(fnOr, 5'd13, 5'd10, 5'd12, 5'd0));
        storeReg(5'd13);
        storeReg(5'd12);
        storeReg(5'd11);
        storeReg(5'd10);
        // Load-use and then a store of loaded data
        emit(iType(opLw, 5'd14, 5'd0, 16'h0004));
        emit(rType(fnAddu, 5'd15, 5'd14, 5'd14, 5'd0));
        storeReg(5'd15);
        emit(iType(opLw, 5'd16, 5'd0, 16'h0008));
        storeReg(5'd16);
        // Taken beq on a fresh result skips one store
        emit(iType(opAddiu, 5'd17, 5'd0, 16'd5));
        emit(iType(opBeq, 5'd17, 5'd17, 16'd2));
        storeReg(5'd17);
        storeReg(5'd2);
        storeReg(5'd3);
        emit(iType(opBne, 5'd17, 5'd17, 16'd1));
        storeReg(5'd5);
        storeReg(5'd6);
        // Branches on loaded registers
        emit(iType(opLw, 5'd18, 5'd0, 16'h000c));
        emit(iType(opBeq, 5'd18, 5'd17, 16'd1));
        storeReg(5'd18);
        storeReg(5'd7);
        emit(iType(opLw, 5'd19, 5'd0, 16'h0010));
        emit(iType(opBne, 5'd19, 5'd0, 16'd1));
        storeReg(5'd19);
        storeReg(5'd8);
        emit(jump(progLen + 3));
        storeReg(5'd9);
        storeReg(5'd2);
        storeReg(5'd3);
        // Countdown loop whose delay slot store runs on every pass
        emit(iType(opOri, 5'd20, 5'd0, 16'd3));
        emit(iType(opAddiu, 5'd20, 5'd20, 16'hffff));
        emit(iType(opBne, 5'd20, 5'd0, 16'hfffe));
        storeReg(5'd20);
        // Writes to r0 have no effect
        emit(iType(opAddiu, 5'd0, 5'd0, 16'h1234));
        storeReg(5'd0);
        emit(iType(opLw, 5'd0, 5'd0, 16'h0014));
        emit(rType(fnAddu, 5'd21, 5'd0, 5'd0, 5'd0));
        storeReg(5'd21);
        storeReg(5'd0);
    endtask

    task automatic buildRandom();
        int   i;
        int   kind;
        int   idx;
        logic prevBranch;
        prevBranch = 1'b0;
        for (i = 0; i < 60; i++)
        begin
            kind = int'(randBits(3));
            if (kind == 7 && prevBranch)
                kind = 0;
            case (kind)
                0, 1, 2:
                begin
                    idx = int'(randBits(4)) % 11;
                    emit(rType(rFuncs[idx], randReg(), randReg(), randReg(), randReg()));
                end
                3, 4:
                begin
                    idx = int'(randBits(3)) % 7;
                    emit(iType(iOps[idx], randReg(), randReg(), 16'(randBits(16))));
                end
                5: emit(iType(opLw, randReg(), 5'd0, {6'd0, 8'(randBits(8)), 2'b00}));
                6: emit(iType(opSw, randReg(), 5'd0, {6'd0, 8'(randBits(8)), 2'b00}));
                default: emit(iType(randBits(1) ? opBne : opBeq, randReg(), randReg(),
                                    16'(randBits(2))));
            endcase
            prevBranch = kind == 7;
        end
        // Padding covers the longest forward branch
        for (i = 0; i < 5; i++)
            emit(32'h0);
        emit(jump(progLen));
        emit(32'h0);
    endtask

    // ISA model with a delay slot that collects stores and loads up to the final jump to itself
    function automatic int runReference();
        wordT    regs [0:31];
        wordT    mem [0:255];
        wordT    pc, npc, cur, ins, a, b, sImm, zImm, res, addr;
        logic    wr;
        regAddrT dst;
        int      i;
        int      step;
        for (i = 0; i < 32; i++)
            regs[i] = '0;
        for (i = 0; i < 256; i++)
            mem[i] = dataMem[i];
        pc = resetPc;
        npc = resetPc + 32'd4;
        for (step = 0; step < 5000; step++)
        begin
            cur = pc;
            ins = instMem[cur[9:2]];
            pc = npc;
            npc = npc + 32'd4;
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            sImm = {{16{ins[15]}}, ins[15:0]};
            zImm = {16'h0000, ins[15:0]};
            addr = a + sImm;
            dst = ins[20:16];
            wr = 1'b1;
            res = '0;
            case (ins[31:26])
                opR:
                begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        fnSll:   res = b << ins[10:6];
                        fnSrl:   res = b >> ins[10:6];
                        fnSra:   res = $signed(b) >>> ins[10:6];
                        fnAddu:  res = a + b;
                        fnSubu:  res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnXor:   res = a ^ b;
                        fnNor:   res = ~(a | b);
                        fnSlt:   res = {31'd0, $signed(a) < $signed(b)};
                        fnSltu:  res = {31'd0, a < b};
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: res = a + sImm;
                opSlti:  res = {31'd0, $signed(a) < $signed(sImm)};
                opSltiu: res = {31'd0, a < sImm};
                opAndi:  res = a & zImm;
                opOri:   res = a | zImm;
                opXori:  res = a ^ zImm;
                opLui:   res = {ins[15:0], 16'h0000};
                opLw:
                begin
                    res = mem[addr[9:2]];
                    loadAddr.push_back(addr[31:2]);
                end
                opSw:
                begin
                    wr = 1'b0;
                    mem[addr[9:2]] = b;
                    expAddr.push_back(addr[31:2]);
                    expData.push_back(b);
                end
                opBeq:
                begin
                    wr = 1'b0;
                    if (a == b)
                        npc = pc + {sImm[29:0], 2'b00};
                end
                opBne:
                begin
                    wr = 1'b0;
                    if (a != b)
                        npc = pc + {sImm[29:0], 2'b00};
                end
                opJ:
                begin
                    wr = 1'b0;
                    npc = {pc[31:28], ins[25:0], 2'b00};
                    if (npc == cur)
                        return expAddr.size();
                end
                default: wr = 1'b0;
            endcase
            if (wr)
                regs[dst] = res;
            regs[0] = '0;
        end
        $display("Reference model ran %0d steps without reaching the final jump", step);
        otherErrors++;
        return expAddr.size();
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, expected);
            valueErrors++;
        end
    endtask

    // Store and load checker sampled mid-cycle
    always @(negedge clk)
    begin
        if (rstN && dataWrite)
        begin
            if (seen < expCount)
            begin
                checkValue("dataAddr", {2'b00, dataAddr}, {2'b00, expAddr[seen]});
                checkValue("dataOut", dataOut, expData[seen]);
            end
            else
            begin
                $display("Unexpected store number %0d to word address %h", seen + 1, dataAddr);
                otherErrors++;
            end
            seen++;
        end
        if (rstN && dataRead)
        begin
            if (loadsSeen < loadCount)
                checkValue("dataAddr on load", {2'b00, dataAddr},
                           {2'b00, loadAddr[loadsSeen]});
            else
            begin
                $display("Unexpected load number %0d from word address %h",
                         loadsSeen + 1, dataAddr);
                otherErrors++;
            end
            loadsSeen++;
        end
    end

    task automatic waitForAccesses(input int count, input int loads);
        int cycles;
        cycles = 0;
        while ((seen < count || loadsSeen < loads) && cycles < 20000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (seen < count || loadsSeen < loads)
        begin
            $display("Timeout after %0d cycles with %0d of %0d stores and %0d of %0d loads seen",
                     cycles, seen, count, loadsSeen, loads);
            otherErrors++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        rstN = 1'b0;
        instIn = '0;
        dataIn = '0;
        lfsr = 16'd45199;
        progLen = 0;
        storeSlot = 0;
        seen = 0;
        expCount = 0;
        loadsSeen = 0;
        loadCount = 0;
        valueErrors = 0;
        otherErrors = 0;
        fillMemories();
        buildDirected();
        buildRandom();
        expCount = runReference();
        loadCount = loadAddr.size();
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        waitForAccesses(expCount, loadCount);
        // Extra stores after the last one show up here
        repeat (30) @(posedge clk);
        $display("Stores %0d of %0d, loads %0d of %0d, value errors %0d, other errors %0d",
                 seen, expCount, loadsSeen, loadCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/mipsPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/hazardUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsCore.sv
verification/tbMips.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tbMips -o simTbMips

./obj_dir/simTbMips | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
